// File: logic/rv_pkg.sv
/*
  Shared RV32I types: opcodes, funct3 codes, ALU and mux selects,
  instruction format union, control word and data bus request
*/
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_t;

  // ------------------------------
  // funct3 codes
  // ------------------------------
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_fn_t;

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JALR} pc_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_t;

  // ------------------------------
  // Instruction formats
  // ------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    alu_fn_t alu_fn;
    logic    op_a_pc;
    logic    op_b_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    wb_sel_t wb_sel;
    pc_sel_t pc_sel;
  } ctl_t;

  // Outgoing data bus request
  typedef struct packed {
    xlen_t      address;
    xlen_t      write_data;
    logic [3:0] byte_enable;
    logic       read_enable;
    logic       write_enable;
  } dbus_t;

endpackage

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
/*
  Integer register file, x1..x31 writable, x0 reads zero
*/
module rv_regfile
  import rv_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     write_enable,
  input  xlen_t    write_data,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data
);

  xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd != '0) begin
      regs[rd] <= write_data;
    end
  end

  // Combinational reads, x0 kept zero by the write guard
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  x0_reads_zero: assert property (@(posedge clock) disable iff (reset)
    (rs1 == '0) |-> (rs1_data == '0))
    else $error("x0 read back as %h", rs1_data);

endmodule

// File: logic/rv_datapath.sv
`timescale 1ns/1ps
/*
  Single-cycle datapath: PC register, register file, immediate
  generation, ALU, writeback mux and next-PC selection
*/
module rv_datapath
  import rv_pkg::*;
#(
  parameter xlen_t RESET_VECTOR = '0
) (
  input  logic  clock,
  input  logic  reset,
  input  inst_u inst,
  input  ctl_t  ctl,
  input  xlen_t load_data,
  output xlen_t alu_result,
  output xlen_t store_data,
  output logic  alu_zero,
  output xlen_t pc
);

  xlen_t imm;
  xlen_t rs1_data;
  xlen_t op_a;
  xlen_t op_b;
  xlen_t pc_plus4;
  xlen_t wb_data;
  xlen_t next_pc;

  rv_regfile i_regfile (
    .clock        (clock),
    .reset        (reset),
    .rs1          (inst.r_fmt.rs1),
    .rs2          (inst.r_fmt.rs2),
    .rd           (inst.r_fmt.rd),
    .write_enable (ctl.reg_write),
    .write_data   (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (store_data)
  );

  // ------------------------------
  // Immediate by format
  // ------------------------------
  always_comb begin
    case (inst.r_fmt.opcode)
      OPC_LUI, OPC_AUIPC: imm = {inst.u_fmt.imm_31_12, 12'b0};
      OPC_JAL: imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                      inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
      OPC_BRANCH: imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                         inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
      OPC_STORE: imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                        inst.s_fmt.imm_4_0};
      default: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    endcase
  end

  assign op_a = ctl.op_a_pc ? pc : rs1_data;
  assign op_b = ctl.op_b_imm ? imm : store_data;

  always_comb begin
    case (ctl.alu_fn)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << op_b[4:0];
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> op_b[4:0];
      ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = op_b;
    endcase
  end

  // Branch compares read this
  assign alu_zero = (alu_result == '0);

  // ------------------------------
  // Writeback and next PC
  // ------------------------------
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctl.wb_sel)
      WB_LOAD: wb_data = load_data;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctl.pc_sel)
      PC_BRANCH: next_pc = pc + imm;
      PC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_VECTOR;
    end else begin
      pc <= next_pc;
    end
  end

  pc_aligned: assert property (@(posedge clock) !reset |=> (pc[1:0] == 2'b00))
    else $error("pc %h is not word aligned", pc);

endmodule

// File: logic/rv_ctlpath.sv
`timescale 1ns/1ps
/*
  Control path: opcode decode, ALU function decode and
  branch resolution into the control word
*/
module rv_ctlpath
  import rv_pkg::*;
(
  input  logic  reset,
  input  inst_u inst,
  input  logic  alu_zero,
  output ctl_t  ctl
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  alu_fn_t    op_fn;
  alu_fn_t    branch_fn;
  logic       branch_taken;

  assign opcode = inst.r_fmt.opcode;
  assign funct3 = inst.r_fmt.funct3;
  assign funct7 = inst.r_fmt.funct7;

  // ALU function for OP and OP_IMM
  always_comb begin
    case (funct3)
      F3_ADD_SUB: op_fn = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      F3_SLL:     op_fn = ALU_SLL;
      F3_SLT:     op_fn = ALU_SLT;
      F3_SLTU:    op_fn = ALU_SLTU;
      F3_XOR:     op_fn = ALU_XOR;
      F3_SR:      op_fn = funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:      op_fn = ALU_OR;
      F3_AND:     op_fn = ALU_AND;
      default:    op_fn = ALU_ADD;
    endcase
  end

  // Compare via SUB/SLT/SLTU, then read the zero flag
  always_comb begin
    case (funct3)
      F3_BEQ, F3_BNE:   branch_fn = ALU_SUB;
      F3_BLT, F3_BGE:   branch_fn = ALU_SLT;
      default:          branch_fn = ALU_SLTU;
    endcase
    case (funct3)
      F3_BEQ, F3_BGE, F3_BGEU: branch_taken = alu_zero;
      default:                 branch_taken = !alu_zero;
    endcase
  end

  // ------------------------------
  // Main decode
  // ------------------------------
  always_comb begin
    ctl = '0;
    ctl.alu_fn = ALU_ADD;
    ctl.wb_sel = WB_ALU;
    ctl.pc_sel = PC_PLUS4;
    case (opcode)
      OPC_LUI: begin
        ctl.alu_fn    = ALU_PASS_B;
        ctl.op_b_imm  = 1'b1;
        ctl.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        ctl.op_a_pc   = 1'b1;
        ctl.op_b_imm  = 1'b1;
        ctl.reg_write = 1'b1;
      end
      OPC_JAL: begin
        ctl.reg_write = 1'b1;
        ctl.wb_sel    = WB_PC4;
        ctl.pc_sel    = PC_BRANCH;
      end
      OPC_JALR: begin
        ctl.op_b_imm  = 1'b1;
        ctl.reg_write = 1'b1;
        ctl.wb_sel    = WB_PC4;
        ctl.pc_sel    = PC_JALR;
      end
      OPC_BRANCH: begin
        ctl.alu_fn = branch_fn;
        ctl.pc_sel = branch_taken ? PC_BRANCH : PC_PLUS4;
      end
      OPC_LOAD: begin
        ctl.op_b_imm  = 1'b1;
        ctl.mem_read  = 1'b1;
        ctl.reg_write = 1'b1;
        ctl.wb_sel    = WB_LOAD;
      end
      OPC_STORE: begin
        ctl.op_b_imm  = 1'b1;
        ctl.mem_write = 1'b1;
      end
      OPC_OP_IMM: begin
        ctl.alu_fn    = op_fn;
        ctl.op_b_imm  = 1'b1;
        ctl.reg_write = 1'b1;
      end
      OPC_OP: begin
        ctl.alu_fn    = op_fn;
        ctl.reg_write = 1'b1;
      end
      // fence and system ops just fall through to PC+4
      OPC_MISC_MEM, OPC_SYSTEM: ;
      default: ;
    endcase
    if (reset) begin
      ctl.reg_write = 1'b0;
      ctl.mem_read  = 1'b0;
      ctl.mem_write = 1'b0;
    end
  end

endmodule

// File: logic/rv_dmem_interface.sv
`timescale 1ns/1ps
/*
  Data memory lane logic: store replication and byte enables,
  load extraction with sign or zero extension
*/
module rv_dmem_interface
  import rv_pkg::*;
(
  input  logic [2:0] funct3,
  input  logic [1:0] address_low,
  input  xlen_t      store_data,
  input  xlen_t      bus_read_data,
  output xlen_t      load_data,
  output xlen_t      bus_write_data,
  output logic [3:0] byte_enable
);

  xlen_t shifted;

  // Store side, value copied to every lane
  always_comb begin
    case (funct3)
      F3_B, F3_BU: begin
        bus_write_data = {4{store_data[7:0]}};
        byte_enable    = 4'b0001 << address_low;
      end
      F3_H, F3_HU: begin
        bus_write_data = {2{store_data[15:0]}};
        byte_enable    = address_low[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        bus_write_data = store_data;
        byte_enable    = 4'b1111;
      end
    endcase
  end

  // Load side, addressed lane down to bit 0
  assign shifted = bus_read_data >> {address_low, 3'b000};

  always_comb begin
    case (funct3)
      F3_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
      F3_BU:   load_data = {24'b0, shifted[7:0]};
      F3_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
      F3_HU:   load_data = {16'b0, shifted[15:0]};
      default: load_data = bus_read_data;
    endcase
  end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps
/*
  RV32I single-cycle core top: datapath, control path and
  data memory lane logic joined onto the data bus
*/
module rv_core
  import rv_pkg::*;
#(
  parameter xlen_t RESET_VECTOR = '0
) (
  input  logic  clock,
  input  logic  reset,
  input  xlen_t inst,
  input  xlen_t bus_read_data,
  output xlen_t pc,
  output dbus_t dbus
);

  inst_u      inst_fields;
  ctl_t       ctl;
  xlen_t      alu_result;
  xlen_t      store_data;
  xlen_t      load_data;
  xlen_t      bus_write_data;
  logic [3:0] byte_enable;
  logic       alu_zero;

  assign inst_fields = inst;

  rv_datapath #(
    .RESET_VECTOR (RESET_VECTOR)
  ) i_datapath (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst_fields),
    .ctl        (ctl),
    .load_data  (load_data),
    .alu_result (alu_result),
    .store_data (store_data),
    .alu_zero   (alu_zero),
    .pc         (pc)
  );

  rv_ctlpath i_ctlpath (
    .reset    (reset),
    .inst     (inst_fields),
    .alu_zero (alu_zero),
    .ctl      (ctl)
  );

  rv_dmem_interface i_dmem_interface (
    .funct3         (inst_fields.i_fmt.funct3),
    .address_low    (alu_result[1:0]),
    .store_data     (store_data),
    .bus_read_data  (bus_read_data),
    .load_data      (load_data),
    .bus_write_data (bus_write_data),
    .byte_enable    (byte_enable)
  );

  // Word address on the bus, lanes picked by byte_enable
  always_comb begin
    dbus.address      = {alu_result[31:2], 2'b00};
    dbus.write_data   = bus_write_data;
    dbus.byte_enable  = byte_enable;
    dbus.read_enable  = ctl.mem_read;
    dbus.write_enable = ctl.mem_write;
  end

  half_aligned: assert property (@(posedge clock) disable iff (reset)
    ((dbus.read_enable || dbus.write_enable) && inst_fields.i_fmt.funct3[1:0] == 2'b01)
      |-> !alu_result[0])
    else $error("halfword access at odd address %h", alu_result);

endmodule

// File: include/rv_ref_model.svh
/*
  Instruction-level RV32I reference: model state type and the
  step function giving next state, bus request and next PC
*/
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

typedef struct {
  xlen_t pc;
  xlen_t regs [32];
  xlen_t mem [256];
} ref_state_t;

// Bus fields left X are don't-care for that instruction
function automatic void rv_ref_step(inout ref_state_t st, input xlen_t iw,
                                    output dbus_t exp_bus, output xlen_t exp_pc);
  xlen_t a, b, b2, res, addr, word, wdata;
  xlen_t imm_i, imm_s, imm_b, imm_j;
  logic [2:0] f3;
  logic [3:0] be;
  logic wr, take;
  f3 = iw[14:12];
  a = st.regs[iw[19:15]];
  b = st.regs[iw[24:20]];
  imm_i = {{20{iw[31]}}, iw[31:20]};
  imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
  imm_b = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
  imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
  exp_bus = 'x;
  exp_bus.read_enable = 1'b0;
  exp_bus.write_enable = 1'b0;
  exp_pc = st.pc + 32'd4;
  res = 'x;
  wr = 1'b1;
  case (iw[6:0])
    OPC_LUI:   res = {iw[31:12], 12'b0};
    OPC_AUIPC: res = st.pc + {iw[31:12], 12'b0};
    OPC_JAL: begin
      res = st.pc + 32'd4;
      exp_pc = st.pc + imm_j;
    end
    OPC_JALR: begin
      res = st.pc + 32'd4;
      exp_pc = (a + imm_i) & ~32'd1;
    end
    OPC_BRANCH: begin
      wr = 1'b0;
      case (f3)
        F3_BEQ:  take = (a == b);
        F3_BNE:  take = (a != b);
        F3_BLT:  take = ($signed(a) < $signed(b));
        F3_BGE:  take = ($signed(a) >= $signed(b));
        F3_BLTU: take = (a < b);
        default: take = (a >= b);
      endcase
      if (take) exp_pc = st.pc + imm_b;
    end
    OPC_LOAD: begin
      addr = a + imm_i;
      word = st.mem[addr[9:2]] >> {addr[1:0], 3'b000};
      case (f3)
        F3_B:    res = {{24{word[7]}}, word[7:0]};
        F3_BU:   res = {24'b0, word[7:0]};
        F3_H:    res = {{16{word[15]}}, word[15:0]};
        F3_HU:   res = {16'b0, word[15:0]};
        default: res = st.mem[addr[9:2]];
      endcase
      exp_bus.address = {addr[31:2], 2'b00};
      exp_bus.read_enable = 1'b1;
    end
    OPC_STORE: begin
      wr = 1'b0;
      addr = a + imm_s;
      case (f3)
        F3_B: begin
          wdata = {4{b[7:0]}};
          be = 4'b0001 << addr[1:0];
        end
        F3_H: begin
          wdata = {2{b[15:0]}};
          be = addr[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          wdata = b;
          be = 4'b1111;
        end
      endcase
      for (int i = 0; i < 4; i++) begin
        if (be[i]) st.mem[addr[9:2]][8*i +: 8] = wdata[8*i +: 8];
      end
      exp_bus.address = {addr[31:2], 2'b00};
      exp_bus.write_data = wdata;
      exp_bus.byte_enable = be;
      exp_bus.write_enable = 1'b1;
    end
    OPC_OP, OPC_OP_IMM: begin
      b2 = (iw[6:0] == OPC_OP_IMM) ? imm_i : b;
      case (f3)
        F3_ADD_SUB: res = (iw[6:0] == OPC_OP && iw[30]) ? a - b2 : a + b2;
        F3_SLL:     res = a << b2[4:0];
        F3_SLT:     res = {31'b0, $signed(a) < $signed(b2)};
        F3_SLTU:    res = {31'b0, a < b2};
        F3_XOR:     res = a ^ b2;
        F3_SR:      res = iw[30] ? xlen_t'($signed(a) >>> b2[4:0]) : a >> b2[4:0];
        F3_OR:      res = a | b2;
        default:    res = a & b2;
      endcase
    end
    default: wr = 1'b0;
  endcase
  if (wr && iw[11:7] != 5'd0) st.regs[iw[11:7]] = res;
  st.pc = exp_pc;
endfunction

`endif

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps
/*
  Testbench for rv_core: clock and reset, program generation,
  instruction and data memory models, compare tasks and checker
*/
module rv_core_tb
  import rv_pkg::*;
();

  `include "rv_ref_model.svh"

  localparam xlen_t RESET_VECTOR = '0;
  localparam int    STEP_LIMIT   = 2000;

  localparam logic [2:0] BRANCH_CONDS [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  localparam logic [2:0] LOAD_KINDS [5]   = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
  localparam logic [2:0] STORE_KINDS [3]  = '{F3_B, F3_H, F3_W};
  localparam int         A_VALS [3]       = '{5, -3, 7};
  localparam int         B_VALS [3]       = '{5, 7, -3};

  logic  clock;
  logic  reset;
  xlen_t inst;
  xlen_t bus_read_data;
  xlen_t pc;
  dbus_t dbus;

  xlen_t      prog [1024];
  xlen_t      dmem [256];
  int         prog_len;
  xlen_t      halt_pc;
  ref_state_t st;

  rv_core #(
    .RESET_VECTOR (RESET_VECTOR)
  ) i_rv_core (
    .clock         (clock),
    .reset         (reset),
    .inst          (inst),
    .bus_read_data (bus_read_data),
    .pc            (pc),
    .dbus          (dbus)
  );

  // Both memories answer in the same cycle
  assign inst          = prog[pc[11:2]];
  assign bus_read_data = dmem[dbus.address[9:2]];

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic xlen_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd, opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t s_type(logic [11:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {off[11:5], rs2, rs1, f3, off[4:0], OPC_STORE};
  endfunction

  function automatic xlen_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic xlen_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic xlen_t j_type(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // Fill pattern over the whole word index
  function automatic xlen_t fill_word(int idx);
    logic [7:0] a;
    a = 8'(idx);
    return {a ^ 8'hc3, ~a, a + 8'h5a, {a[3:0], a[7:4]} ^ 8'h81};
  endfunction

  // Random word offset below max_word, plus a lane legal for the width
  function automatic logic [11:0] lane_offset(logic [2:0] f3, int max_word);
    logic [11:0] off;
    off = 12'($urandom_range(0, max_word - 1) * 4);
    if (f3 == F3_B || f3 == F3_BU) begin
      off = off + 12'($urandom_range(0, 3));
    end else if (f3 == F3_H || f3 == F3_HU) begin
      off = off + 12'(2 * $urandom_range(0, 1));
    end
    return off;
  endfunction

  function automatic xlen_t random_alu();
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        alt;
    f3  = 3'($urandom_range(0, 7));
    rd  = reg_idx_t'($urandom_range(0, 15));
    rs1 = reg_idx_t'($urandom_range(0, 15));
    rs2 = reg_idx_t'($urandom_range(0, 15));
    alt = 1'($urandom_range(0, 1));
    if ($urandom_range(0, 1) == 1) begin
      if (f3 == F3_ADD_SUB || f3 == F3_SR) begin
        return r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPC_OP);
      end
      return r_type(7'b0, rs2, rs1, f3, rd, OPC_OP);
    end
    imm = 12'($urandom());
    if (f3 == F3_SLL) begin
      imm[11:5] = 7'b0;
    end else if (f3 == F3_SR) begin
      imm[11:5] = {1'b0, alt, 5'b0};
    end
    return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
  endfunction

  // ------------------------------
  // Program builder
  // ------------------------------
  task automatic emit(input xlen_t word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic load_const(input reg_idx_t rd, input xlen_t value);
    xlen_t upper;
    // ADDI sign-extends, so round the upper part
    upper = value + 32'h800;
    emit(u_type(upper[31:12], rd, OPC_LUI));
    emit(i_type(value[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM));
  endtask

  task automatic store_word(input reg_idx_t rs, input logic [11:0] off);
    emit(s_type(off, rs, 5'd0, F3_W));
  endtask

  task automatic build_program();
    logic [2:0] f3;
    reg_idx_t   rd;
    for (int i = 0; i < 1024; i++) begin
      prog[i] = 32'h0000_0013;
    end
    prog_len = 0;
    // A store sits at the boot address while reset is high
    store_word(5'd0, 12'h3f8);
    for (int r = 1; r < 16; r++) begin
      load_const(reg_idx_t'(r), xlen_t'($urandom()));
    end
    // Random ALU mix, then dump x0..x15
    for (int n = 0; n < 48; n++) begin
      emit(random_alu());
    end
    for (int r = 0; r < 16; r++) begin
      store_word(reg_idx_t'(r), 12'(12'h200 + 4 * r));
    end
    // Byte, half and word stores
    for (int n = 0; n < 12; n++) begin
      f3 = STORE_KINDS[n % 3];
      emit(s_type(lane_offset(f3, 128), reg_idx_t'($urandom_range(1, 15)), 5'd0, f3));
    end
    // Each load followed by a store of its target
    for (int n = 0; n < 15; n++) begin
      f3 = LOAD_KINDS[n % 5];
      rd = reg_idx_t'(16 + n % 4);
      emit(i_type(lane_offset(f3, 256), 5'd0, f3, rd, OPC_LOAD));
      store_word(rd, 12'(12'h380 + 4 * n));
    end
    // All six branches, fall-through counted in x23
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit(i_type(12'(A_VALS[p]), 5'd0, F3_ADD_SUB, 5'd21, OPC_OP_IMM));
        emit(i_type(12'(B_VALS[p]), 5'd0, F3_ADD_SUB, 5'd22, OPC_OP_IMM));
        emit(b_type(13'd8, 5'd22, 5'd21, BRANCH_CONDS[c]));
        emit(i_type(12'd1, 5'd23, F3_ADD_SUB, 5'd23, OPC_OP_IMM));
      end
    end
    // Short backward loop
    emit(i_type(12'd3, 5'd0, F3_ADD_SUB, 5'd27, OPC_OP_IMM));
    emit(i_type(12'hfff, 5'd27, F3_ADD_SUB, 5'd27, OPC_OP_IMM));
    emit(b_type(13'h1ffc, 5'd0, 5'd27, F3_BNE));
    // JAL over two fillers, JALR with odd offset lands on a word
    emit(j_type(21'd12, 5'd24));
    emit(i_type(12'd64, 5'd23, F3_ADD_SUB, 5'd23, OPC_OP_IMM));
    emit(i_type(12'd64, 5'd23, F3_ADD_SUB, 5'd23, OPC_OP_IMM));
    emit(u_type(20'd0, 5'd25, OPC_AUIPC));
    emit(i_type(12'd17, 5'd25, 3'b000, 5'd26, OPC_JALR));
    emit(i_type(12'd256, 5'd23, F3_ADD_SUB, 5'd23, OPC_OP_IMM));
    emit(i_type(12'd256, 5'd23, F3_ADD_SUB, 5'd23, OPC_OP_IMM));
    store_word(5'd23, 12'h3c0);
    store_word(5'd24, 12'h3c4);
    store_word(5'd25, 12'h3c8);
    store_word(5'd26, 12'h3cc);
    store_word(5'd27, 12'h3d0);
    // Writes aimed at x0
    emit(i_type(12'h123, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
    emit(u_type(20'habcde, 5'd0, OPC_LUI));
    emit(r_type(7'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP));
    emit(i_type(12'h010, 5'd0, F3_W, 5'd0, OPC_LOAD));
    emit(j_type(21'd4, 5'd0));
    store_word(5'd0, 12'h3f0);
    halt_pc = RESET_VECTOR + xlen_t'(4 * prog_len);
    emit(j_type(21'd0, 5'd0));
  endtask

  task automatic reset_model();
    st.pc = RESET_VECTOR;
    for (int i = 0; i < 32; i++) begin
      st.regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      st.mem[i] = fill_word(i);
    end
  endtask

  task automatic commit_store(input dbus_t req);
    for (int i = 0; i < 4; i++) begin
      if (req.byte_enable[i]) begin
        dmem[req.address[9:2]][8*i +: 8] <= req.write_data[8*i +: 8];
      end
    end
  endtask

  // ------------------------------
  // Failure reporting and compares
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input xlen_t got, input xlen_t exp);
    $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    abort_run("value mismatch on the DUT outputs");
  endtask

  // Address and data only matter when the matching enable is expected
  task automatic check_dbus(input dbus_t got, input dbus_t exp);
    if (got.read_enable !== exp.read_enable) begin
      report_mismatch("dbus.read_enable", xlen_t'(got.read_enable), xlen_t'(exp.read_enable));
    end
    if (got.write_enable !== exp.write_enable) begin
      report_mismatch("dbus.write_enable", xlen_t'(got.write_enable), xlen_t'(exp.write_enable));
    end
    if ((exp.read_enable || exp.write_enable) && got.address !== exp.address) begin
      report_mismatch("dbus.address", got.address, exp.address);
    end
    if (exp.write_enable && got.write_data !== exp.write_data) begin
      report_mismatch("dbus.write_data", got.write_data, exp.write_data);
    end
    if (exp.write_enable && got.byte_enable !== exp.byte_enable) begin
      report_mismatch("dbus.byte_enable", xlen_t'(got.byte_enable), xlen_t'(exp.byte_enable));
    end
  endtask

  task automatic check_pc(input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      report_mismatch("pc", got, exp);
    end
  endtask

  // ------------------------------
  // Stimulus and checking
  // ------------------------------
  initial begin
    dbus_t idle_bus;
    dbus_t exp_bus;
    dbus_t bus_req;
    xlen_t exp_pc;
    xlen_t boot_word;
    int    steps;
    void'($urandom(76370));
    reset <= 1'b1;
    for (int i = 0; i < 256; i++) begin
      dmem[i] <= fill_word(i);
    end
    build_program();
    reset_model();
    idle_bus = '0;

    // Held in reset with a load, then the first store, at the boot address
    boot_word = prog[0];
    prog[0] = i_type(12'h3f8, 5'd0, F3_W, 5'd1, OPC_LOAD);
    for (int c = 1; c <= 16; c++) begin
      @(posedge clock);
      if (c == 8) begin
        prog[0] <= boot_word;
      end
      if (c == 16) begin
        reset <= 1'b0;
      end
      #1;
      check_pc(pc, RESET_VECTOR);
      if (c < 16) begin
        check_dbus(dbus, idle_bus);
      end
    end

    // One instruction per cycle until the halt loop
    steps = 0;
    while (pc != halt_pc && steps < STEP_LIMIT) begin
      @(negedge clock);
      bus_req = dbus;
      rv_ref_step(st, prog[st.pc[11:2]], exp_bus, exp_pc);
      check_dbus(bus_req, exp_bus);
      @(posedge clock);
      if (bus_req.write_enable) begin
        commit_store(bus_req);
      end
      #1;
      check_pc(pc, exp_pc);
      steps++;
    end

    if (pc == halt_pc) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run("timeout: program never reached its halt loop");
    end
  end

endmodule

// File: rv_simple.f
+incdir+include
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_datapath.sv
logic/rv_ctlpath.sv
logic/rv_dmem_interface.sv
logic/rv_core.sv
testbench/rv_core_tb.sv

// File: Makefile
# Verilator flow for the rv_simple core
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= rv_simple.f
TB_TOP     ?= rv_core_tb
RTL_TOP    ?= rv_core
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
	  -Mdir $(BUILD_DIR) -o V$(TB_TOP)

# A $fatal in the testbench gives a non-zero exit status here
sim: build
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
